//--- Bender.yml
package:
  name: gpu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/gpu_pkg.sv
      - rtl/ram_if.sv
      - rtl/block_ram.sv
      - rtl/host_access.sv
      - rtl/register_file.sv
      - rtl/shader_core.sv
      - rtl/gpu.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/gpu_checker.sv
      - bench/gpu_tb.sv

//--- bench/gpu_checker.sv
`timescale 1ns/100ps

// Concurrent checks on the control outputs of the shader core.
module gpu_checker (
    input logic                 clock,
    input logic                 rst_n,
    input logic                 run,
    input logic                 halted,
    input logic                 exception,
    input gpu_pkg::exc_data_t   exception_data,
    input gpu_pkg::core_state_e state,
    input logic                 data_write
);
    import gpu_pkg::*;

    // Read by the testbench watchdog.
    int failures = 0;

    exception_needs_halted: assert property (@(posedge clock) disable iff (!rst_n)
        exception |-> halted)
        else begin
            failures++;
            $error("exception is set while halted is low");
        end

    // A stopped core is parked, so halted stays low.
    halted_only_when_running: assert property (@(posedge clock) disable iff (!rst_n)
        !run |=> !halted)
        else begin
            failures++;
            $error("halted is set although run was low");
        end

    exception_data_held: assert property (@(posedge clock) disable iff (!rst_n)
        halted && run |=> $stable(exception_data))
        else begin
            failures++;
            $error("exception_data changed while the core was halted");
        end

    no_store_in_fetch: assert property (@(posedge clock) disable iff (!rst_n)
        state == FETCH |-> !data_write)
        else begin
            failures++;
            $error("data RAM write during FETCH");
        end

endmodule

//--- bench/gpu_tb.sv
`timescale 1ns/100ps
`include "gpu_macros.svh"

module gpu_tb;
    import gpu_pkg::*;

    localparam int RAM_WORDS        = 1 << `GPU_RAM_WORDS_LOG2;
    localparam int RAM_BYTES        = RAM_WORDS * 4;
    localparam int CHECK_WORDS      = 64;
    localparam int MODEL_STEP_LIMIT = 5000;

    logic       clock;
    logic       rst_n;
    logic       run;
    logic       halted;
    logic       exception;
    exc_data_t  exception_data;
    logic       ext_enable_write_inst;
    byte_addr_t ext_inst_address;
    word_t      ext_inst_input;
    word_t      ext_inst_output;
    logic       ext_enable_write_data;
    byte_addr_t ext_data_address;
    word_t      ext_data_input;
    word_t      ext_data_output;
    reg_index_t ext_register_address;
    word_t      ext_register_output;
    reg_index_t ext_specialreg_address;
    word_t      ext_specialreg_output;

    // Expected machine state kept by the reference model.
    word_t      exp_inst [RAM_WORDS];
    word_t      exp_data [RAM_WORDS];
    word_t      exp_regs [16];
    byte_addr_t exp_pc;
    word_t      exp_retired;
    exc_data_t  exp_exc;

    word_t       prog [$];
    logic [31:0] lfsr_state  = 32'd98144;
    int          cycle_count = 0;
    int          cycle_limit = 2000;
    int          total_steps = 0;
    opcode_e     alu_ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI};

    gpu UUT (.*);

    bind shader_core gpu_checker checker_inst (
        .clock          (clock),
        .rst_n          (rst_n),
        .run            (run),
        .halted         (halted),
        .exception      (exception),
        .exception_data (exception_data),
        .state          (state),
        .data_write     (data_port.write)
    );

    always #4 clock = ~clock;

    // Watchdog that also picks up assertion failures from the checker.
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the test did not finish within %0d cycles.", cycle_limit);
            $display("CHECKS FAILED");
            $fatal(1, "Simulation stopped by the watchdog.");
        end else if (UUT.core.checker_inst.failures != 0) begin
            $display("An assertion on the core control outputs failed.");
            $display("CHECKS FAILED");
            $fatal(1, "Simulation stopped after an assertion failure.");
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit.
    function automatic word_t rand_bits(input int count);
        word_t value;
        logic  feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic word_t enc_r(input opcode_e op, input int rd, input int rs1, input int rs2);
        return {op, 4'(rd), 4'(rs1), 4'(rs2), 12'h000};
    endfunction

    function automatic word_t enc_i(input opcode_e op, input int rd, input int rs1, input int imm);
        return {op, 4'(rd), 4'(rs1), 16'(imm)};
    endfunction

    function automatic word_t random_alu_inst();
        opcode_e op;
        int      rd;
        int      rs1;
        int      rs2;
        int      imm;
        op  = alu_ops[rand_bits(3) % 5];
        rd  = rand_bits(4);
        rs1 = rand_bits(4);
        if (op == OP_ADDI) begin
            imm = rand_bits(16);
            return enc_i(op, rd, rs1, imm);
        end
        rs2 = rand_bits(4);
        return enc_r(op, rd, rs1, rs2);
    endfunction

    function automatic logic [7:0] addr_fault(input word_t address);
        if (address[1:0] != 2'b00) begin
            return EXC_MISALIGNED;
        end
        if (address >= RAM_BYTES) begin
            return EXC_OUT_OF_RANGE;
        end
        return EXC_NONE;
    endfunction

    function automatic void set_reg(input logic [3:0] index, input word_t value);
        if (index != 4'd0) begin
            exp_regs[index] = value;
        end
    endfunction

    // Reference ISA model. Runs from PC 0 and returns the instructions executed.
    function automatic int run_model();
        word_t      inst;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      target;
        logic [7:0] op;
        logic [7:0] code;
        logic [3:0] rd;
        logic       done;
        int         steps;
        exp_pc      = '0;
        exp_retired = '0;
        exp_exc     = '0;
        done        = 1'b0;
        steps       = 0;
        while (!done && steps < MODEL_STEP_LIMIT) begin
            inst  = exp_inst[exp_pc[11:2]];
            op    = inst[31:24];
            rd    = inst[23:20];
            imm   = {{16{inst[15]}}, inst[15:0]};
            a     = exp_regs[inst[19:16]];
            b     = (op == OP_STORE || op == OP_BNE) ? exp_regs[rd] : exp_regs[inst[15:12]];
            code  = EXC_NONE;
            steps = steps + 1;
            case (op)
                OP_HALT: done = 1'b1;
                OP_ADD:  set_reg(rd, a + b);
                OP_SUB:  set_reg(rd, a - b);
                OP_AND:  set_reg(rd, a & b);
                OP_XOR:  set_reg(rd, a ^ b);
                OP_ADDI: set_reg(rd, a + imm);
                OP_LOAD: begin
                    code = addr_fault(a + imm);
                    if (code == EXC_NONE) begin
                        set_reg(rd, exp_data[(a + imm) >> 2]);
                    end
                end
                OP_STORE: begin
                    code = addr_fault(a + imm);
                    if (code == EXC_NONE) begin
                        exp_data[(a + imm) >> 2] = b;
                    end
                end
                OP_BNE: begin
                    target = word_t'(exp_pc) + 32'd4 + imm;
                    if (a != b) begin
                        code = addr_fault(target);
                    end
                end
                default: code = EXC_ILLEGAL_OP;
            endcase
            if (code != EXC_NONE) begin
                exp_exc = {code, exp_pc};
                done    = 1'b1;
            end else begin
                exp_retired = exp_retired + 1;
                if (!done) begin
                    exp_pc = (op == OP_BNE && a != b) ? target[15:0] : exp_pc + 16'd4;
                end
            end
        end
        return steps;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "Value mismatch in %s.", name);
        end
    endtask

    // One host write per cycle. The strobe is sampled on the next edge.
    task automatic host_write(input logic to_inst, input int index, input word_t value);
        @(posedge clock);
        ext_enable_write_inst <= to_inst;
        ext_enable_write_data <= !to_inst;
        if (to_inst) begin
            ext_inst_address <= byte_addr_t'(index * 4);
            ext_inst_input   <= value;
            exp_inst[index]   = value;
        end else begin
            ext_data_address <= byte_addr_t'(index * 4);
            ext_data_input   <= value;
            exp_data[index]   = value;
        end
    endtask

    task automatic host_idle();
        @(posedge clock);
        ext_enable_write_inst <= 1'b0;
        ext_enable_write_data <= 1'b0;
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            host_write(1'b1, i, prog[i]);
        end
        host_idle();
    endtask

    // Pipelined read-back where the data for an address shows one cycle later.
    task automatic read_back(input string name);
        for (int i = 0; i <= CHECK_WORDS; i++) begin
            @(posedge clock);
            if (i < CHECK_WORDS) begin
                ext_inst_address <= byte_addr_t'(i * 4);
                ext_data_address <= byte_addr_t'(i * 4);
            end
            @(negedge clock);
            if (i > 0) begin
                check_value($sformatf("%s inst[%0d]", name, i - 1), exp_inst[i - 1],
                            ext_inst_output);
                check_value($sformatf("%s data[%0d]", name, i - 1), exp_data[i - 1],
                            ext_data_output);
            end
        end
    endtask

    task automatic run_and_check(input string name);
        word_t special [3];
        total_steps += run_model();
        cycle_limit  = 2000 + 4 * total_steps;
        @(posedge clock);
        run <= 1'b1;
        do @(negedge clock); while (!halted);
        check_value({name, " exception"}, word_t'(exp_exc[23:16] != 8'd0), exception);
        check_value({name, " exception_data"}, exp_exc, exception_data);
        for (int i = 0; i < 16; i++) begin
            @(posedge clock);
            ext_register_address <= reg_index_t'(i);
            @(negedge clock);
            check_value($sformatf("%s r%0d", name, i), exp_regs[i], ext_register_output);
        end
        special = '{word_t'(exp_pc), exp_retired, '0};
        for (int i = 0; i < 3; i++) begin
            @(posedge clock);
            ext_specialreg_address <= reg_index_t'(i);
            @(negedge clock);
            check_value($sformatf("%s special%0d", name, i), special[i], ext_specialreg_output);
        end
    endtask

    task automatic stop_and_verify(input string name);
        @(posedge clock);
        run <= 1'b0;
        read_back(name);
    endtask

    initial begin
        clock                  = 1'b0;
        rst_n                  = 1'b0;
        run                    = 1'b0;
        ext_enable_write_inst  = 1'b0;
        ext_enable_write_data  = 1'b0;
        ext_inst_address       = '0;
        ext_data_address       = '0;
        ext_inst_input         = '0;
        ext_data_input         = '0;
        ext_register_address   = '0;
        ext_specialreg_address = '0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            exp_inst[i] = '0;
            exp_data[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            exp_regs[i] = '0;
        end

        repeat (10) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_value("reset halted", '0, halted);
        check_value("reset exception", '0, exception);
        check_value("reset exception_data", '0, exception_data);
        check_value("reset pc", '0, ext_specialreg_output);

        // Host load and read-back of both RAMs.
        for (int i = 0; i < CHECK_WORDS; i++) begin
            host_write(1'b1, i, rand_bits(32));
        end
        for (int i = 0; i < CHECK_WORDS; i++) begin
            host_write(1'b0, i, rand_bits(32));
        end
        host_idle();
        read_back("memory load");

        // Random ALU program.
        prog.delete();
        for (int r = 1; r < 16; r++) begin
            prog.push_back(enc_i(OP_ADDI, r, 0, rand_bits(16)));
        end
        for (int i = 0; i < 24; i++) begin
            prog.push_back(random_alu_inst());
        end
        // A write to register 0 must be dropped.
        prog.push_back(enc_r(OP_ADD, 0, 1, 2));
        prog.push_back(enc_r(OP_HALT, 0, 0, 0));
        load_program();
        run_and_check("alu program");
        stop_and_verify("alu program");

        // Sum words 0..15 into word 48 and copy them to words 32..47.
        for (int i = 0; i < 16; i++) begin
            host_write(1'b0, i, rand_bits(32));
        end
        prog = '{enc_i(OP_ADDI, 1, 0, 0), enc_i(OP_ADDI, 2, 0, 64), enc_i(OP_ADDI, 3, 0, 0),
                 enc_i(OP_LOAD, 4, 1, 0), enc_r(OP_ADD, 3, 3, 4), enc_i(OP_STORE, 4, 1, 128),
                 enc_i(OP_ADDI, 1, 1, 4), enc_i(OP_BNE, 1, 2, -20),
                 enc_i(OP_STORE, 3, 0, 192), enc_r(OP_HALT, 0, 0, 0)};
        load_program();
        run_and_check("copy loop");
        stop_and_verify("copy loop");

        // Faults from an illegal opcode, a misaligned LOAD and an out-of-range STORE.
        prog = '{enc_i(OP_ADDI, 5, 0, 16'h55), enc_i(OP_ADDI, 9, 0, 16'h99),
                 {8'h2A, 4'd5, 4'd9, 16'h0000}, enc_r(OP_HALT, 0, 0, 0)};
        load_program();
        run_and_check("illegal opcode");
        stop_and_verify("illegal opcode");
        prog = '{enc_i(OP_ADDI, 1, 0, 64), enc_i(OP_LOAD, 6, 1, 2), enc_r(OP_HALT, 0, 0, 0)};
        load_program();
        run_and_check("misaligned load");
        stop_and_verify("misaligned load");
        prog = '{enc_i(OP_ADDI, 1, 0, 4096), enc_i(OP_STORE, 1, 1, 0), enc_r(OP_HALT, 0, 0, 0)};
        load_program();
        run_and_check("out of range store");
        stop_and_verify("out of range store");

        // Host strobes while running must not reach the RAMs.
        prog = '{enc_i(OP_ADDI, 7, 7, 1), enc_r(OP_HALT, 0, 0, 0)};
        load_program();
        run_and_check("protected run");
        for (int i = 0; i < 8; i++) begin
            @(posedge clock);
            ext_enable_write_inst <= 1'b1;
            ext_enable_write_data <= 1'b1;
            ext_inst_address      <= byte_addr_t'(i * 4);
            ext_data_address      <= byte_addr_t'(i * 4);
            ext_inst_input        <= rand_bits(32);
            ext_data_input        <= rand_bits(32);
        end
        host_idle();
        stop_and_verify("protected run");

        // A second start runs from PC 0 with the count cleared.
        run_and_check("restart");
        stop_and_verify("restart");

        if (UUT.core.checker_inst.failures != 0) begin
            $display("CHECKS FAILED");
            $fatal(1, "The core checker reported assertion failures.");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

//--- include/gpu_macros.svh
`ifndef GPU_MACROS_SVH
`define GPU_MACROS_SVH

// Width of a data or instruction word.
`define GPU_WORD_WIDTH 32

// Width of a host or core byte address.
`define GPU_ADDRESS_WIDTH 16

// Each RAM holds 2**10 words, indexed by byte address bits 11:2.
`define GPU_RAM_WORDS_LOG2 10

// Sixteen integer registers.
`define GPU_REG_COUNT_LOG2 4

`endif

//--- rtl/block_ram.sv
`timescale 1ns/100ps
`include "gpu_macros.svh"

module block_ram (
    input logic clock,
    ram_if.ram  port
);
    import gpu_pkg::*;

    localparam int unsigned DEPTH = 1 << `GPU_RAM_WORDS_LOG2;

    word_t mem [DEPTH];

    // Write on the strobe edge.
    always_ff @(posedge clock) begin
        if (port.write) begin
            mem[port.address] <= port.write_data;
        end
    end

    // The read is registered, so a same-cycle write to the word
    // still returns the old contents.
    always_ff @(posedge clock) begin
        port.read_data <= mem[port.address];
    end

endmodule

//--- rtl/gpu.sv
`timescale 1ns/100ps

module gpu (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                run,

    output logic                halted,
    output logic                exception,
    output gpu_pkg::exc_data_t  exception_data,

    input  logic                ext_enable_write_inst,
    input  gpu_pkg::byte_addr_t ext_inst_address,
    input  gpu_pkg::word_t      ext_inst_input,
    output gpu_pkg::word_t      ext_inst_output,

    input  logic                ext_enable_write_data,
    input  gpu_pkg::byte_addr_t ext_data_address,
    input  gpu_pkg::word_t      ext_data_input,
    output gpu_pkg::word_t      ext_data_output,

    input  gpu_pkg::reg_index_t ext_register_address,
    output gpu_pkg::word_t      ext_register_output,

    input  gpu_pkg::reg_index_t ext_specialreg_address,
    output gpu_pkg::word_t      ext_specialreg_output
);
    import gpu_pkg::*;

    reg_index_t rf_index_a;
    reg_index_t rf_index_b;
    word_t      rf_data_a;
    word_t      rf_data_b;
    logic       rf_write;
    reg_index_t rf_write_index;
    word_t      rf_write_data;

    ram_if core_inst_port ();
    ram_if core_data_port ();
    ram_if inst_ram_port ();
    ram_if data_ram_port ();

    block_ram inst_ram (
        .clock (clock),
        .port  (inst_ram_port)
    );

    block_ram data_ram (
        .clock (clock),
        .port  (data_ram_port)
    );

    host_access access (
        .run                   (run),
        .ext_enable_write_inst (ext_enable_write_inst),
        .ext_enable_write_data (ext_enable_write_data),
        .ext_inst_address      (ext_inst_address),
        .ext_data_address      (ext_data_address),
        .ext_inst_input        (ext_inst_input),
        .ext_data_input        (ext_data_input),
        .core_inst             (core_inst_port),
        .core_data             (core_data_port),
        .inst_ram              (inst_ram_port),
        .data_ram              (data_ram_port)
    );

    register_file regs (
        .clock        (clock),
        .rst_n        (rst_n),
        .read_index_a (rf_index_a),
        .read_index_b (rf_index_b),
        .host_index   (ext_register_address),
        .read_data_a  (rf_data_a),
        .read_data_b  (rf_data_b),
        .host_data    (ext_register_output),
        .write        (rf_write),
        .write_index  (rf_write_index),
        .write_data   (rf_write_data)
    );

    shader_core core (
        .clock          (clock),
        .rst_n          (rst_n),
        .run            (run),
        .halted         (halted),
        .exception      (exception),
        .exception_data (exception_data),
        .inst_port      (core_inst_port),
        .data_port      (core_data_port),
        .rf_index_a     (rf_index_a),
        .rf_index_b     (rf_index_b),
        .rf_data_a      (rf_data_a),
        .rf_data_b      (rf_data_b),
        .rf_write       (rf_write),
        .rf_write_index (rf_write_index),
        .rf_write_data  (rf_write_data),
        .special_index  (ext_specialreg_address),
        .special_data   (ext_specialreg_output)
    );

    // Host read-back sees the RAM output directly.
    assign ext_inst_output = inst_ram_port.read_data;
    assign ext_data_output = data_ram_port.read_data;

endmodule

//--- rtl/gpu_pkg.sv
`include "gpu_macros.svh"

package gpu_pkg;

    typedef logic [`GPU_WORD_WIDTH-1:0]     word_t;
    typedef logic [`GPU_ADDRESS_WIDTH-1:0]  byte_addr_t;
    typedef logic [`GPU_RAM_WORDS_LOG2-1:0] word_index_t;
    typedef logic [`GPU_REG_COUNT_LOG2-1:0] reg_index_t;

    // Exception code in the top byte, faulting PC below it.
    typedef logic [8+`GPU_ADDRESS_WIDTH-1:0] exc_data_t;

    typedef enum logic [7:0] {
        OP_HALT  = 8'h00,
        OP_ADD   = 8'h01,
        OP_SUB   = 8'h02,
        OP_AND   = 8'h03,
        OP_XOR   = 8'h04,
        OP_ADDI  = 8'h05,
        OP_LOAD  = 8'h06,
        OP_STORE = 8'h07,
        OP_BNE   = 8'h08
    } opcode_e;

    typedef enum logic [7:0] {
        EXC_NONE         = 8'd0,
        EXC_ILLEGAL_OP   = 8'd1,
        EXC_MISALIGNED   = 8'd2,
        EXC_OUT_OF_RANGE = 8'd3
    } exc_code_e;

    typedef enum logic [2:0] {IDLE, FETCH, EXECUTE, MEM_WAIT, DONE} core_state_e;

endpackage

//--- rtl/host_access.sv
`timescale 1ns/100ps
`include "gpu_macros.svh"

module host_access (
    input  logic                run,
    input  logic                ext_enable_write_inst,
    input  logic                ext_enable_write_data,
    input  gpu_pkg::byte_addr_t ext_inst_address,
    input  gpu_pkg::byte_addr_t ext_data_address,
    input  gpu_pkg::word_t      ext_inst_input,
    input  gpu_pkg::word_t      ext_data_input,
    ram_if.ram                  core_inst,
    ram_if.ram                  core_data,
    ram_if.master               inst_ram,
    ram_if.master               data_ram
);
    import gpu_pkg::*;

    // Host addresses are in bytes, the RAMs are word indexed.
    function automatic word_index_t to_index(input byte_addr_t address);
        return address[`GPU_RAM_WORDS_LOG2+1:2];
    endfunction

    // Instruction RAM.
    // Only the host ever writes it, and only while the core is stopped.
    always_comb begin
        if (run) begin
            inst_ram.address    = core_inst.address;
            inst_ram.write      = 1'b0;
            inst_ram.write_data = '0;
        end else begin
            inst_ram.address    = to_index(ext_inst_address);
            inst_ram.write      = ext_enable_write_inst;
            inst_ram.write_data = ext_inst_input;
        end
    end

    // Data RAM is owned by the core while it runs.
    always_comb begin
        if (run) begin
            data_ram.address    = core_data.address;
            data_ram.write      = core_data.write;
            data_ram.write_data = core_data.write_data;
        end else begin
            data_ram.address    = to_index(ext_data_address);
            data_ram.write      = ext_enable_write_data;
            data_ram.write_data = ext_data_input;
        end
    end

    assign core_inst.read_data = inst_ram.read_data;
    assign core_data.read_data = data_ram.read_data;

endmodule

//--- rtl/ram_if.sv
`timescale 1ns/100ps

// One word-addressed RAM port.
interface ram_if;
    import gpu_pkg::*;

    word_index_t address;
    logic        write;
    word_t       write_data;
    word_t       read_data;

    modport master (
        output address, write, write_data,
        input  read_data
    );

    modport ram (
        input  address, write, write_data,
        output read_data
    );
endinterface

//--- rtl/register_file.sv
`timescale 1ns/100ps
`include "gpu_macros.svh"

module register_file (
    input  logic                clock,
    input  logic                rst_n,
    input  gpu_pkg::reg_index_t read_index_a,
    input  gpu_pkg::reg_index_t read_index_b,
    input  gpu_pkg::reg_index_t host_index,
    output gpu_pkg::word_t      read_data_a,
    output gpu_pkg::word_t      read_data_b,
    output gpu_pkg::word_t      host_data,
    input  logic                write,
    input  gpu_pkg::reg_index_t write_index,
    input  gpu_pkg::word_t      write_data
);
    import gpu_pkg::*;

    localparam int unsigned REG_COUNT = 1 << `GPU_REG_COUNT_LOG2;

    word_t regs [REG_COUNT];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write && write_index != '0) begin
            regs[write_index] <= write_data;
        end
    end

    // Register 0 is hardwired to zero.
    assign read_data_a = (read_index_a == '0) ? '0 : regs[read_index_a];
    assign read_data_b = (read_index_b == '0) ? '0 : regs[read_index_b];
    assign host_data   = (host_index == '0) ? '0 : regs[host_index];

endmodule

//--- rtl/shader_core.sv
`timescale 1ns/100ps
`include "gpu_macros.svh"

module shader_core (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                run,
    output logic                halted,
    output logic                exception,
    output gpu_pkg::exc_data_t  exception_data,
    ram_if.master               inst_port,
    ram_if.master               data_port,
    output gpu_pkg::reg_index_t rf_index_a,
    output gpu_pkg::reg_index_t rf_index_b,
    input  gpu_pkg::word_t      rf_data_a,
    input  gpu_pkg::word_t      rf_data_b,
    output logic                rf_write,
    output gpu_pkg::reg_index_t rf_write_index,
    output gpu_pkg::word_t      rf_write_data,
    input  gpu_pkg::reg_index_t special_index,
    output gpu_pkg::word_t      special_data
);
    import gpu_pkg::*;

    localparam int unsigned RAM_BYTES = 1 << (`GPU_RAM_WORDS_LOG2 + 2);

    core_state_e state;
    byte_addr_t  pc;
    word_t       retired;

    word_t       inst;
    opcode_e     opcode;
    reg_index_t  rd;
    reg_index_t  rs1;
    reg_index_t  rs2;
    word_t       imm;
    word_t       mem_addr;
    word_t       branch_target;
    byte_addr_t  pc_plus4;
    logic        branch_taken;
    logic        alu_op;
    word_t       alu_result;
    exc_code_e   fault_code;

    function automatic exc_code_e check_address(input word_t address);
        exc_code_e code;
        code = EXC_NONE;
        if (address[1:0] != 2'b00) begin
            code = EXC_MISALIGNED;
        end else if (address >= RAM_BYTES) begin
            code = EXC_OUT_OF_RANGE;
        end
        return code;
    endfunction

    // Instruction word stays valid through EXECUTE and MEM_WAIT,
    // since the fetch address only moves when PC does.
    assign inst   = inst_port.read_data;
    assign opcode = opcode_e'(inst[31:24]);
    assign rd     = inst[23:20];
    assign rs1    = inst[19:16];
    assign rs2    = inst[15:12];
    assign imm    = {{16{inst[15]}}, inst[15:0]};

    // STORE and BNE read rd on the second port.
    assign rf_index_a = rs1;
    assign rf_index_b = (opcode == OP_STORE || opcode == OP_BNE) ? rd : rs2;

    assign mem_addr      = rf_data_a + imm;
    assign pc_plus4      = pc + byte_addr_t'(4);
    assign branch_target = word_t'(pc) + word_t'(4) + imm;
    assign branch_taken  = (rf_data_a != rf_data_b);

    always_comb begin
        alu_op = 1'b1;
        case (opcode)
            OP_ADD:  alu_result = rf_data_a + rf_data_b;
            OP_SUB:  alu_result = rf_data_a - rf_data_b;
            OP_AND:  alu_result = rf_data_a & rf_data_b;
            OP_XOR:  alu_result = rf_data_a ^ rf_data_b;
            OP_ADDI: alu_result = rf_data_a + imm;
            default: begin
                alu_op     = 1'b0;
                alu_result = '0;
            end
        endcase
    end

    always_comb begin
        case (opcode)
            OP_HALT, OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI: fault_code = EXC_NONE;
            OP_LOAD, OP_STORE: fault_code = check_address(mem_addr);
            // Only a taken branch can fault on its target.
            OP_BNE:  fault_code = branch_taken ? check_address(branch_target) : EXC_NONE;
            default: fault_code = EXC_ILLEGAL_OP;
        endcase
    end

    assign inst_port.address    = pc[`GPU_RAM_WORDS_LOG2+1:2];
    assign inst_port.write      = 1'b0;
    assign inst_port.write_data = '0;

    assign data_port.address    = mem_addr[`GPU_RAM_WORDS_LOG2+1:2];
    assign data_port.write_data = rf_data_b;
    assign data_port.write      = (state == EXECUTE) && (opcode == OP_STORE)
                                  && (fault_code == EXC_NONE);

    // ALU results retire in EXECUTE, load data one cycle later.
    assign rf_write       = ((state == EXECUTE) && alu_op) || (state == MEM_WAIT);
    assign rf_write_index = rd;
    assign rf_write_data  = (state == MEM_WAIT) ? data_port.read_data : alu_result;

    always_ff @(posedge clock) begin
        // Dropping run parks the core just like reset.
        if (!rst_n || !run) begin
            state          <= IDLE;
            pc             <= '0;
            retired        <= '0;
            halted         <= 1'b0;
            exception      <= 1'b0;
            exception_data <= '0;
        end else begin
            case (state)
                IDLE: state <= FETCH;
                FETCH: state <= EXECUTE;
                EXECUTE: begin
                    if (fault_code != EXC_NONE) begin
                        state          <= DONE;
                        halted         <= 1'b1;
                        exception      <= 1'b1;
                        exception_data <= {fault_code, pc};
                    end else if (opcode == OP_HALT) begin
                        // PC is left on the HALT instruction.
                        state   <= DONE;
                        halted  <= 1'b1;
                        retired <= retired + 1'b1;
                    end else if (opcode == OP_LOAD) begin
                        state <= MEM_WAIT;
                    end else begin
                        state   <= FETCH;
                        retired <= retired + 1'b1;
                        if (opcode == OP_BNE && branch_taken) begin
                            pc <= branch_target[`GPU_ADDRESS_WIDTH-1:0];
                        end else begin
                            pc <= pc_plus4;
                        end
                    end
                end
                MEM_WAIT: begin
                    state   <= FETCH;
                    pc      <= pc_plus4;
                    retired <= retired + 1'b1;
                end
                default: state <= DONE;
            endcase
        end
    end

    // Special registers for the host.
    always_comb begin
        case (special_index)
            reg_index_t'(0): special_data = word_t'(pc);
            reg_index_t'(1): special_data = retired;
            default:         special_data = '0;
        endcase
    end

endmodule

//--- verilog.f
+incdir+include
rtl/gpu_pkg.sv
rtl/ram_if.sv
rtl/block_ram.sv
rtl/host_access.sv
rtl/register_file.sv
rtl/shader_core.sv
rtl/gpu.sv
bench/gpu_checker.sv
bench/gpu_tb.sv
